// File: Bender.yml
package:
  name: pipeCore16

sources:
  - corePkg.sv
  - hazardDetect.sv
  - fetchStage.sv
  - regFile.sv
  - decodeStage.sv
  - executeStage.sv
  - memStage.sv
  - cpuTop.sv
  - target: test
    files:
      - tbCpu.sv

// File: corePkg.sv
`default_nettype none

package corePkg;

    // word and register index sizes, fixed by the ISA
    localparam int dataWidth    = 16;
    localparam int regAddrWidth = 3;

    // major opcodes, instr[15:11]
    localparam logic [4:0] opHalt  = 5'b00000;
    localparam logic [4:0] opNop   = 5'b00001;
    localparam logic [4:0] opAddi  = 5'b01000;
    localparam logic [4:0] opLd    = 5'b10001;
    localparam logic [4:0] opSt    = 5'b10000;
    localparam logic [4:0] opArith = 5'b11011;
    localparam logic [4:0] opBeqz  = 5'b01100;
    localparam logic [4:0] opBnez  = 5'b01101;

    // arith group select, instr[1:0]
    localparam logic [1:0] fnAdd  = 2'b00;
    localparam logic [1:0] fnSub  = 2'b01;
    localparam logic [1:0] fnXor  = 2'b10;
    localparam logic [1:0] fnAndn = 2'b11;

    // register-register format
    typedef struct packed {
        logic [4:0]              opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
        logic [1:0]              funct;
    } rFmt_s;

    // immediate format, branches use {rd, imm5} as an 8-bit displacement
    typedef struct packed {
        logic [4:0]              opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rd;
        logic [4:0]              imm5;
    } iFmt_s;

    typedef union packed {
        rFmt_s rFmt;
        iFmt_s iFmt;
    } instrWord_u;

    localparam logic [dataWidth-1:0] nopWord = {opNop, 11'b0};

    // one pending or committed register write
    typedef struct packed {
        logic                    valid;
        logic [regAddrWidth-1:0] addr;
        logic [dataWidth-1:0]    data;
    } regWrite_s;

    typedef struct packed {
        logic                 valid;
        logic [4:0]           op;
        logic [1:0]           funct;
        logic [dataWidth-1:0] rsVal;
        logic [dataWidth-1:0] rtVal;
        logic [dataWidth-1:0] imm;
        // data field stays zero until writeback
        regWrite_s            dest;
        logic                 isLoad;
        logic                 isStore;
        logic                 isBranch;
        logic                 isHalt;
        logic [dataWidth-1:0] pc2;
    } decEx_s;

    typedef struct packed {
        logic                 valid;
        logic [dataWidth-1:0] result;
        logic [dataWidth-1:0] storeData;
        regWrite_s            dest;
        logic                 isLoad;
        logic                 isStore;
        logic                 isHalt;
    } exMem_s;

    typedef struct packed {
        regWrite_s wr;
        logic      isHalt;
    } memWb_s;

    // wishbone classic, master to slave
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [dataWidth-1:0] adr;
        logic [dataWidth-1:0] dat;
    } wbReq_s;

    // slave to master
    typedef struct packed {
        logic                 ack;
        logic [dataWidth-1:0] dat;
    } wbRsp_s;

endpackage

`default_nettype wire

// File: cpuTests.txt
# kind addr value, all hex; P program word at byte addr, M data word at byte addr
# W expected retire as reg and data in order, S expected store as addr and data, H halt marker
P 0000 4025
P 0002 405D
P 0004 D94C
P 0006 D951
P 0008 DB96
P 000A DA3B
P 000C 412F
P 000E 4130
P 0010 8848
P 0012 886A
P 0014 DA70
P 0016 818C
P 0018 89AC
P 001A 81DE
P 001C 6004
P 001E 40E1
P 0020 40E2
P 0022 6802
P 0024 40E3
P 0026 6F02
P 0028 47E1
P 002A 6102
P 002C 40C2
P 002E 46DF
P 0030 6EFC
P 0032 80E0
P 0034 0000
P 0036 4029
M 0008 1234
M 000A ABCD
W 1 0005
W 2 FFFD
W 3 0002
W 4 FFF8
W 5 FFFA
W 6 FFF8
W 1 0014
W 1 0004
W 2 1234
W 3 ABCD
W 4 BE01
W 5 BE01
W 7 0003
W 6 0002
W 6 0001
W 6 0000
S 0010 BE01
S 0002 FFF8
S 0000 0003
H

// File: cpuTop.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop import corePkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    output logic [dataWidth-1:0] imemAddr,
    input  logic [dataWidth-1:0] imemData,
    output wbReq_s               wbReq,
    input  wbRsp_s               wbRsp,
    output regWrite_s            retire,
    output logic                 halted
);

    instrWord_u              nextInstr;
    instrWord_u              fdInstr;
    logic [dataWidth-1:0]    fdPc;
    logic [dataWidth-1:0]    rsData;
    logic [dataWidth-1:0]    rtData;
    logic [dataWidth-1:0]    branchTarget;
    logic [regAddrWidth-1:0] rsAddr;
    logic [regAddrWidth-1:0] rtAddr;
    regWrite_s               fdDest;
    decEx_s                  decEx;
    exMem_s                  exMem;
    memWb_s                  memWb;
    logic                    memBusy;
    logic                    pcHold;
    logic                    branchTaken;
    logic                    branchInF;
    logic                    branchInD;
    logic                    branchInX;

    // branch flag riding alongside the fd register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            branchInD <= 1'b0;
        end else if (!memBusy) begin
            branchInD <= branchInF;
        end
    end

    assign branchInX = decEx.valid && decEx.isBranch;

    hazardDetect u_hazardDetect (
        .fetchInstr (imemData),
        .pendWrite  ({memWb.wr, exMem.dest, decEx.dest, fdDest}),
        .branchInD  (branchInD),
        .branchInX  (branchInX),
        .nextInstr  (nextInstr),
        .pcHold     (pcHold),
        .branchInF  (branchInF)
    );

    fetchStage u_fetchStage (
        .clk          (clk),
        .rstN         (rstN),
        .memBusy      (memBusy),
        .pcHold       (pcHold),
        .nextInstr    (nextInstr),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .imemAddr     (imemAddr),
        .fdInstr      (fdInstr),
        .fdPc         (fdPc)
    );

    regFile u_regFile (
        .clk    (clk),
        .rstN   (rstN),
        .rsAddr (rsAddr),
        .rtAddr (rtAddr),
        .rsData (rsData),
        .rtData (rtData),
        .wr     (memWb.wr)
    );

    decodeStage u_decodeStage (
        .clk     (clk),
        .rstN    (rstN),
        .memBusy (memBusy),
        .fdInstr (fdInstr),
        .fdPc    (fdPc),
        .rsData  (rsData),
        .rtData  (rtData),
        .rsAddr  (rsAddr),
        .rtAddr  (rtAddr),
        .fdDest  (fdDest),
        .decEx   (decEx)
    );

    executeStage u_executeStage (
        .clk          (clk),
        .rstN         (rstN),
        .memBusy      (memBusy),
        .decEx        (decEx),
        .exMem        (exMem),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget)
    );

    memStage u_memStage (
        .clk     (clk),
        .rstN    (rstN),
        .exMem   (exMem),
        .wbReq   (wbReq),
        .wbRsp   (wbRsp),
        .memBusy (memBusy),
        .memWb   (memWb)
    );

    // writeback stage is the retire point
    assign retire = memWb.wr;

    // sticky once a halt reaches writeback
    always_ff @(posedge clk) begin
        if (!rstN) begin
            halted <= 1'b0;
        end else if (memWb.isHalt) begin
            halted <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage import corePkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    memBusy,
    input  instrWord_u              fdInstr,
    input  logic [dataWidth-1:0]    fdPc,
    input  logic [dataWidth-1:0]    rsData,
    input  logic [dataWidth-1:0]    rtData,
    output logic [regAddrWidth-1:0] rsAddr,
    output logic [regAddrWidth-1:0] rtAddr,
    output regWrite_s               fdDest,
    output decEx_s                  decEx
);

    logic [4:0] op;
    decEx_s     decNext;

    assign op     = fdInstr.rFmt.opcode;
    assign rsAddr = fdInstr.rFmt.rs;
    // bits 7:5 are rt for arith and the data reg for st
    assign rtAddr = fdInstr.rFmt.rt;

    always_comb begin
        decNext          = '0;
        decNext.valid    = (op != opNop);
        decNext.op       = op;
        decNext.funct    = fdInstr.rFmt.funct;
        decNext.rsVal    = rsData;
        decNext.rtVal    = rtData;
        decNext.pc2      = fdPc;
        decNext.isLoad   = (op == opLd);
        decNext.isStore  = (op == opSt);
        decNext.isBranch = (op == opBeqz) || (op == opBnez);
        decNext.isHalt   = (op == opHalt);
        // branch displacement is 8 bits, everything else imm5
        if (decNext.isBranch) begin
            decNext.imm = {{(dataWidth-8){fdInstr.iFmt.rd[2]}},
                           fdInstr.iFmt.rd, fdInstr.iFmt.imm5};
        end else begin
            decNext.imm = {{(dataWidth-5){fdInstr.iFmt.imm5[4]}}, fdInstr.iFmt.imm5};
        end
        case (op)
            opAddi, opLd: begin
                decNext.dest.valid = 1'b1;
                decNext.dest.addr  = fdInstr.iFmt.rd;
            end
            opArith: begin
                decNext.dest.valid = 1'b1;
                decNext.dest.addr  = fdInstr.rFmt.rd;
            end
            default: decNext.dest = '0;
        endcase
    end

    // destination of the word now in decode, seen by hazard unit
    assign fdDest = decNext.dest;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            decEx.valid      <= 1'b0;
            decEx.dest.valid <= 1'b0;
            decEx.isLoad     <= 1'b0;
            decEx.isStore    <= 1'b0;
            decEx.isBranch   <= 1'b0;
            decEx.isHalt     <= 1'b0;
        end else if (!memBusy) begin
            decEx <= decNext;
        end
    end

endmodule

`default_nettype wire

// File: executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage import corePkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 memBusy,
    input  decEx_s               decEx,
    output exMem_s               exMem,
    output logic                 branchTaken,
    output logic [dataWidth-1:0] branchTarget
);

    logic [dataWidth-1:0] aluOut;
    logic                 condMet;
    exMem_s               exNext;

    always_comb begin
        // addi, ld and st address all use rs + imm
        aluOut = decEx.rsVal + decEx.imm;
        if (decEx.op == opArith) begin
            case (decEx.funct)
                fnAdd: aluOut = decEx.rsVal + decEx.rtVal;
                // sub is rt - rs in this ISA
                fnSub: aluOut = decEx.rtVal - decEx.rsVal;
                fnXor: aluOut = decEx.rsVal ^ decEx.rtVal;
                fnAndn: aluOut = decEx.rsVal & ~decEx.rtVal;
            endcase
        end
    end

    // beqz / bnez test rs against zero
    assign condMet = (decEx.op == opBeqz) ? (decEx.rsVal == '0) : (decEx.rsVal != '0);

    assign branchTaken  = decEx.valid && decEx.isBranch && condMet;
    assign branchTarget = decEx.pc2 + decEx.imm;

    always_comb begin
        exNext           = '0;
        exNext.valid     = decEx.valid;
        exNext.result    = aluOut;
        exNext.storeData = decEx.rtVal;
        exNext.dest      = decEx.dest;
        exNext.isLoad    = decEx.isLoad;
        exNext.isStore   = decEx.isStore;
        exNext.isHalt    = decEx.isHalt;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            exMem.valid      <= 1'b0;
            exMem.dest.valid <= 1'b0;
            exMem.isLoad     <= 1'b0;
            exMem.isStore    <= 1'b0;
            exMem.isHalt     <= 1'b0;
        end else if (!memBusy) begin
            exMem <= exNext;
        end
    end

endmodule

`default_nettype wire

// File: fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage import corePkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 memBusy,
    input  logic                 pcHold,
    input  instrWord_u           nextInstr,
    input  logic                 branchTaken,
    input  logic [dataWidth-1:0] branchTarget,
    output logic [dataWidth-1:0] imemAddr,
    output instrWord_u           fdInstr,
    output logic [dataWidth-1:0] fdPc
);

    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] pcPlus2;

    assign pcPlus2  = pc + dataWidth'(2);
    assign imemAddr = pc;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc      <= '0;
            fdInstr <= instrWord_u'(nopWord);
        end else if (!memBusy) begin
            // redirect beats the hold
            if (branchTaken) begin
                pc <= branchTarget;
            end else if (!pcHold) begin
                pc <= pcPlus2;
            end
            fdInstr <= nextInstr;
            // pc+2 travels with the word for branch targets
            fdPc    <= pcPlus2;
        end
    end

endmodule

`default_nettype wire

// File: hazardDetect.sv
`timescale 1ns/1ps
`default_nettype none

module hazardDetect import corePkg::*; (
    input  instrWord_u      fetchInstr,
    // 0 fd, 1 decEx, 2 exMem, 3 memWb
    input  regWrite_s [3:0] pendWrite,
    input  logic            branchInD,
    input  logic            branchInX,
    output instrWord_u      nextInstr,
    output logic            pcHold,
    output logic            branchInF
);

    logic readRs;
    logic readRt;
    logic isBranch;
    logic isHalt;
    logic rsHazard;
    logic rtHazard;
    logic dataHazard;
    logic stall;

    // any in-flight write to this register
    function automatic logic isPending(input logic [regAddrWidth-1:0] r,
                                       input regWrite_s [3:0] pw);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (pw[i].valid && (pw[i].addr == r)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // which source fields the fetched opcode reads
    always_comb begin
        readRs   = 1'b0;
        readRt   = 1'b0;
        isBranch = 1'b0;
        isHalt   = 1'b0;
        case (fetchInstr.rFmt.opcode)
            opHalt: isHalt = 1'b1;
            // reads nothing
            opNop: isHalt = 1'b0;
            // st reads its data reg from bits 7:5, same slot as rt
            opSt, opArith: begin
                readRs = 1'b1;
                readRt = 1'b1;
            end
            opBeqz, opBnez: begin
                readRs   = 1'b1;
                isBranch = 1'b1;
            end
            // addi, ld and anything unknown read rs only
            default: readRs = 1'b1;
        endcase
    end

    assign rsHazard   = readRs && isPending(fetchInstr.rFmt.rs, pendWrite);
    assign rtHazard   = readRt && isPending(fetchInstr.rFmt.rt, pendWrite);
    assign dataHazard = rsHazard || rtHazard;
    assign stall      = dataHazard || branchInD || branchInX;

    assign nextInstr = stall ? instrWord_u'(nopWord) : fetchInstr;
    // high only when a branch actually enters decode
    assign branchInF = isBranch && !stall;

    // with the branch in execute the held pc is released,
    // fetch then takes pc+2 or the redirect
    assign pcHold = dataHazard || branchInD || ((isBranch || isHalt) && !branchInX);

endmodule

`default_nettype wire

// File: memStage.sv
`timescale 1ns/1ps
`default_nettype none

module memStage import corePkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  exMem_s exMem,
    output wbReq_s wbReq,
    input  wbRsp_s wbRsp,
    output logic   memBusy,
    output memWb_s memWb
);

    logic memOp;
    logic access;
    // set the cycle after an ack, forces cyc/stb low for one cycle
    logic ackSeen;

    assign memOp  = exMem.valid && (exMem.isLoad || exMem.isStore);
    assign access = memOp && !ackSeen;

    // request fields held steady by the frozen exMem register
    always_comb begin
        wbReq.cyc = access;
        wbReq.stb = access;
        wbReq.we  = access && exMem.isStore;
        wbReq.adr = exMem.result;
        wbReq.dat = exMem.storeData;
    end

    // freeze until ack, also during the idle cycle between transfers
    assign memBusy = memOp && !(access && wbRsp.ack);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ackSeen <= 1'b0;
        end else begin
            ackSeen <= access && wbRsp.ack;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            memWb.wr.valid <= 1'b0;
            memWb.isHalt   <= 1'b0;
        end else if (memBusy) begin
            // bubble while the transfer waits
            memWb.wr.valid <= 1'b0;
            memWb.isHalt   <= 1'b0;
        end else begin
            memWb.wr.valid <= exMem.valid && exMem.dest.valid;
            memWb.wr.addr  <= exMem.dest.addr;
            // load data sampled in the ack cycle
            memWb.wr.data  <= exMem.isLoad ? wbRsp.dat : exMem.result;
            memWb.isHalt   <= exMem.valid && exMem.isHalt;
        end
    end

endmodule

`default_nettype wire

// File: regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile import corePkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic [regAddrWidth-1:0] rsAddr,
    input  logic [regAddrWidth-1:0] rtAddr,
    output logic [dataWidth-1:0]    rsData,
    output logic [dataWidth-1:0]    rtData,
    input  regWrite_s               wr
);

    logic [dataWidth-1:0] regs [2**regAddrWidth];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 2**regAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // async read, no write-through since hazard unit waits past writeback
    assign rsData = regs[rsAddr];
    assign rtData = regs[rtAddr];

endmodule

`default_nettype wire

// File: src.f
corePkg.sv
hazardDetect.sv
fetchStage.sv
regFile.sv
decodeStage.sv
executeStage.sv
memStage.sv
cpuTop.sv
tbCpu.sv

// File: tbCpu.sv
`timescale 1ns/1ps
`default_nettype none

module tbCpu import corePkg::*; ();

    logic                 clk;
    logic                 rstN;
    logic [dataWidth-1:0] imemAddr;
    logic [dataWidth-1:0] imemData;
    wbReq_s               wbReq;
    wbRsp_s               wbRsp;
    regWrite_s            retire;
    logic                 halted;

    // word-addressed models indexed by byte address bits 8:1
    logic [dataWidth-1:0] imem [256];
    logic [dataWidth-1:0] dmem [256];

    regWrite_s expRetire [$];
    wbReq_s    expStore [$];
    int        retireIdx;
    int        storeIdx;
    int        progWords;
    logic      haltMarker;
    logic      loaded;
    int        seed;
    logic      ackPending;
    int        ackWait;

    cpuTop u_cpuTop (
        .clk      (clk),
        .rstN     (rstN),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .wbReq    (wbReq),
        .wbRsp    (wbRsp),
        .retire   (retire),
        .halted   (halted)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // combinational instruction port
    assign imemData = imem[imemAddr[8:1]];

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkRetire(input regWrite_s got);
        regWrite_s exp;
        exp = expRetire[retireIdx];
        if (got !== exp) begin
            reportFailure($sformatf("MISMATCH at %0t: retire %0d expected r%0d=%h, got r%0d=%h",
                                    $time, retireIdx, exp.addr, exp.data, got.addr, got.data));
        end else begin
            retireIdx++;
        end
    endtask

    task automatic checkStore(input wbReq_s got);
        wbReq_s exp;
        logic   foundLater;
        foundLater = 1'b0;
        if (storeIdx >= expStore.size()) begin
            reportFailure($sformatf("unexpected store of %h to address %h", got.dat, got.adr));
        end else begin
            exp = expStore[storeIdx];
            // a later expected store showing up early means wrong order
            for (int i = storeIdx + 1; i < expStore.size(); i++) begin
                if (expStore[i] === got) begin
                    foundLater = 1'b1;
                end
            end
            if (got === exp) begin
                storeIdx++;
            end else if (foundLater) begin
                reportFailure($sformatf("store to %h arrived out of order", got.adr));
            end else begin
                reportFailure($sformatf(
                    "MISMATCH at %0t: store %0d expected %h to %h, got %h to %h",
                    $time, storeIdx, exp.dat, exp.adr, got.dat, got.adr));
            end
        end
    endtask

    task automatic loadTests();
        int          fd;
        int          code;
        logic [7:0]  kind;
        logic [15:0] a;
        logic [15:0] d;
        string       rest;
        regWrite_s   w;
        wbReq_s      s;
        fd = $fopen("cpuTests.txt", "r");
        if (fd == 0) begin
            reportFailure("could not open cpuTests.txt");
        end else begin
            while ($fscanf(fd, " %c", kind) == 1) begin
                case (kind)
                    "#": code = $fgets(rest, fd);
                    "H": haltMarker = 1'b1;
                    "P", "M", "W", "S": begin
                        code = $fscanf(fd, "%h %h", a, d);
                        if (code != 2) begin
                            reportFailure($sformatf(
                                "line of kind %c in cpuTests.txt lacks two hex fields", kind));
                        end else if (kind == "P") begin
                            imem[a[8:1]] = d;
                            progWords++;
                        end else if (kind == "M") begin
                            dmem[a[8:1]] = d;
                        end else if (kind == "W") begin
                            w.valid = 1'b1;
                            w.addr  = a[regAddrWidth-1:0];
                            w.data  = d;
                            expRetire.push_back(w);
                        end else begin
                            s     = '0;
                            s.cyc = 1'b1;
                            s.stb = 1'b1;
                            s.we  = 1'b1;
                            s.adr = a;
                            s.dat = d;
                            expStore.push_back(s);
                        end
                    end
                    default: reportFailure("unknown line kind in cpuTests.txt");
                endcase
            end
            $fclose(fd);
            if (!haltMarker) begin
                reportFailure("cpuTests.txt has no halt marker line");
            end
        end
    endtask

    // wishbone slave waits 0..3 random cycles before ack
    always @(negedge clk) begin
        if (!rstN) begin
            wbRsp.ack  = 1'b0;
            ackPending = 1'b0;
        end else if (wbRsp.ack) begin
            // taken at the last rising edge
            wbRsp.ack  = 1'b0;
            ackPending = 1'b0;
        end else if (wbReq.cyc && wbReq.stb) begin
            if (!ackPending) begin
                ackPending = 1'b1;
                ackWait    = $random(seed) & 32'h3;
            end else begin
                ackWait = ackWait - 1;
            end
            if (ackWait == 0) begin
                wbRsp.ack = 1'b1;
                wbRsp.dat = dmem[wbReq.adr[8:1]];
            end
        end
    end

    // retire and store monitor sampling at the rising edge
    always @(posedge clk) begin
        if (rstN) begin
            if (retire.valid) begin
                if (halted) begin
                    reportFailure("a register write retired after halt");
                end else if (retireIdx >= expRetire.size()) begin
                    reportFailure("more register writes retired than expected");
                end else begin
                    checkRetire(retire);
                end
            end
            if (wbReq.cyc && wbReq.stb && wbReq.we && wbRsp.ack) begin
                checkStore(wbReq);
                dmem[wbReq.adr[8:1]] = wbReq.dat;
            end
        end
    end

    initial begin
        rstN       = 1'b0;
        wbRsp      = '0;
        seed       = 32'h9c9c22ae;
        retireIdx  = 0;
        storeIdx   = 0;
        progWords  = 0;
        haltMarker = 1'b0;
        loaded     = 1'b0;
        ackPending = 1'b0;
        ackWait    = 0;
        // zero is HALT, so running off the program stops the core
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] = '0;
        end
        loadTests();
        loaded = 1'b1;
        repeat (5) @(negedge clk);
        rstN = 1'b1;
        wait (halted === 1'b1);
        // a few more cycles to catch anything retiring past halt
        repeat (10) @(posedge clk);
        @(negedge clk);
        if (retireIdx != expRetire.size()) begin
            reportFailure($sformatf("only %0d of %0d expected register writes retired",
                                    retireIdx, expRetire.size()));
        end else if (storeIdx != expStore.size()) begin
            reportFailure($sformatf("only %0d of %0d expected stores seen",
                                    storeIdx, expStore.size()));
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

    // watchdog budget grows with program length
    initial begin
        wait (loaded === 1'b1);
        repeat (20 * progWords + 200) @(posedge clk);
        reportFailure("timeout, the core did not halt within the cycle budget");
    end

endmodule

`default_nettype wire
